// ==== src/motor_cfg_pkg.sv ====
package motor_cfg_pkg;

  // ====================================================================
  // timing and widths
  // ====================================================================
  localparam int clk_hz          = 50_000_000;        // fpga_clk_50
  localparam int debounce_cycles = clk_hz / 100_000;  // 10 us settle time
  localparam int debounce_cnt_w  = 10;                // holds debounce_cycles - 1
  localparam int pwm_res         = 8;                 // duty bits
  localparam int pwm_tick_div    = 10;                // clocks per pwm step, 2560 per period
  localparam int pos_w           = 32;
  localparam int err_w           = 8;                 // saturating decode errors

  // ====================================================================
  // payloads
  // ====================================================================
  typedef struct packed {
    logic a;  // channel a, leads on forward motion
    logic b;
  } enc_pins_t;

  typedef struct packed {
    logic [1:0] key_n;  // push keys, low when pressed
  } key_pins_t;

  typedef struct packed {
    logic               enable;
    logic               dir;     // straight to the driver pin
    logic [pwm_res-1:0] duty;
  } motor_ctrl_t;

  typedef struct packed {
    logic signed [pos_w-1:0] position;
    logic [err_w-1:0]        err_count;
  } enc_status_t;

endpackage

// ==== src/axil_pkg.sv ====
package axil_pkg;

  // ====================================================================
  // bus geometry and response codes
  // ====================================================================
  localparam int axil_addr_w = 4;
  localparam int axil_data_w = 32;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // register map, byte addresses
  localparam logic [axil_addr_w-1:0] reg_ctrl_addr   = 4'h0;  // enable, dir, duty
  localparam logic [axil_addr_w-1:0] reg_pos_addr    = 4'h4;  // encoder position, read only
  localparam logic [axil_addr_w-1:0] reg_status_addr = 4'h8;  // keys and err count

  // ====================================================================
  // channel bundles
  // ====================================================================
  // manager side
  typedef struct packed {
    logic [axil_addr_w-1:0]   awaddr;
    logic                     awvalid;
    logic [axil_data_w-1:0]   wdata;
    logic [axil_data_w/8-1:0] wstrb;
    logic                     wvalid;
    logic                     bready;
    logic [axil_addr_w-1:0]   araddr;
    logic                     arvalid;
    logic                     rready;
  } axil_req_t;

  // subordinate side
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   arready;
    logic [axil_data_w-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
  } axil_rsp_t;

endpackage

// ==== src/debounce_filter.sv ====
`timescale 1ns/1ps

module debounce_filter #(
  parameter type      payload_t = logic,
  parameter payload_t rst_val   = '0   // idle level of the pins
) (
  input  logic     fpga_clk_50,
  input  logic     hps_fpga_reset_n,
  input  payload_t raw,
  output payload_t clean
);

  payload_t sync_1;   // first metastability stage
  payload_t sync_2;   // usable synchronized copy
  payload_t clean_q;
  logic [motor_cfg_pkg::debounce_cnt_w-1:0] stable_cnt;

  // ====================================================================
  // synchronizer plus stable-time counter
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sync_1     <= rst_val;
      sync_2     <= rst_val;
      clean_q    <= rst_val;
      stable_cnt <= '0;
    end
    else
    begin
      sync_1 <= raw;
      sync_2 <= sync_1;
      if (sync_1 != sync_2)
        stable_cnt <= '0;            // input still moving, start over
      else if (sync_2 == clean_q)
        stable_cnt <= '0;            // nothing new to accept
      else if (stable_cnt == motor_cfg_pkg::debounce_cnt_w'(motor_cfg_pkg::debounce_cycles - 1))
      begin
        clean_q    <= sync_2;        // held long enough
        stable_cnt <= '0;
      end
      else
        stable_cnt <= stable_cnt + 1'b1;
    end
  end

  assign clean = clean_q;

endmodule

// ==== src/quad_decoder.sv ====
`timescale 1ns/1ps

module quad_decoder (
  input  logic                        fpga_clk_50,
  input  logic                        hps_fpga_reset_n,
  input  motor_cfg_pkg::enc_pins_t    pins,
  output motor_cfg_pkg::enc_status_t  status
);

  motor_cfg_pkg::enc_pins_t prev_pins;   // last a,b state
  logic signed [motor_cfg_pkg::pos_w-1:0] pos_q;
  logic [motor_cfg_pkg::err_w-1:0]        err_q;
  logic [3:0] trans;                      // {prev a, prev b, a, b}

  assign trans = {prev_pins, pins};

  // ====================================================================
  // transition decode
  // forward order 00 -> 10 -> 11 -> 01 -> 00 on {a,b}
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      prev_pins <= '0;
      pos_q     <= '0;
      err_q     <= '0;
    end
    else
    begin
      prev_pins <= pins;
      case (trans)
        4'b0010, 4'b1011, 4'b1101, 4'b0100:
          pos_q <= pos_q + 1;             // forward step
        4'b1000, 4'b1110, 4'b0111, 4'b0001:
          pos_q <= pos_q - 1;             // reverse step
        4'b0011, 4'b1100, 4'b1001, 4'b0110:
        begin
          // both channels moved, direction unknown
          if (err_q != '1)
            err_q <= err_q + 1'b1;        // saturate at all ones
        end
        default:
          ;                               // no change on the pins
      endcase
    end
  end

  assign status.position  = pos_q;
  assign status.err_count = err_q;

endmodule

// ==== src/pwm_generator.sv ====
`timescale 1ns/1ps

module pwm_generator (
  input  logic                       fpga_clk_50,
  input  logic                       hps_fpga_reset_n,
  input  motor_cfg_pkg::motor_ctrl_t ctrl,
  output logic                       pwm_out
);

  logic [$clog2(motor_cfg_pkg::pwm_tick_div)-1:0] tick_cnt;  // clocks within one step
  logic [motor_cfg_pkg::pwm_res-1:0] period_cnt;
  logic [motor_cfg_pkg::pwm_res-1:0] duty_q;   // duty of the running period
  logic enable_q;
  logic tick;

  assign tick = (tick_cnt == $bits(tick_cnt)'(motor_cfg_pkg::pwm_tick_div - 1));

  // ====================================================================
  // prescaler, period counter and compare
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      tick_cnt   <= '0;
      period_cnt <= '0;
      duty_q     <= '0;
      enable_q   <= 1'b0;
      pwm_out    <= 1'b0;
    end
    else
    begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick)
      begin
        period_cnt <= period_cnt + 1'b1;   // wraps every 256 steps
        if (period_cnt == '1)
        begin
          enable_q <= ctrl.enable;         // new setting only on a period edge
          duty_q   <= ctrl.duty;
        end
      end
      pwm_out <= enable_q && (period_cnt < duty_q);  // duty 0 never high
    end
  end

endmodule

// ==== src/axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs (
  input  logic                        fpga_clk_50,
  input  logic                        hps_fpga_reset_n,
  input  axil_pkg::axil_req_t         req,
  output axil_pkg::axil_rsp_t         rsp,
  input  motor_cfg_pkg::enc_status_t  enc,
  input  motor_cfg_pkg::key_pins_t    keys,
  output motor_cfg_pkg::motor_ctrl_t  ctrl
);

  logic       awready_q;   // drives awready and wready together
  logic       bvalid_q;
  logic [1:0] bresp_q;
  logic       arready_q;
  logic       rvalid_q;
  logic [1:0] rresp_q;
  logic [axil_pkg::axil_data_w-1:0] rdata_q;
  logic [axil_pkg::axil_data_w-1:0] rd_mux;   // read value at the arready cycle
  logic [1:0] rd_resp;
  logic       wr_hs;
  logic       rd_hs;
  motor_cfg_pkg::motor_ctrl_t ctrl_q;

  assign wr_hs = awready_q & req.awvalid & req.wvalid;
  assign rd_hs = arready_q & req.arvalid;

  // ====================================================================
  // write channel
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= axil_pkg::resp_okay;
      ctrl_q    <= '0;
    end
    else
    begin
      // one-cycle ready, blocked while a response waits
      awready_q <= req.awvalid & req.wvalid & ~bvalid_q & ~awready_q;
      if (wr_hs)
      begin
        bvalid_q <= 1'b1;
        bresp_q  <= axil_pkg::resp_okay;
        case (req.awaddr)
          axil_pkg::reg_ctrl_addr:
          begin
            if (req.wstrb[0])
            begin
              ctrl_q.enable <= req.wdata[0];
              ctrl_q.dir    <= req.wdata[1];
            end
            if (req.wstrb[1])
              ctrl_q.duty <= req.wdata[8 +: motor_cfg_pkg::pwm_res];
          end
          axil_pkg::reg_pos_addr, axil_pkg::reg_status_addr:
            ;                                        // read only, write dropped
          default:
            bresp_q <= axil_pkg::resp_slverr;        // unmapped
        endcase
      end
      else if (bvalid_q && req.bready)
        bvalid_q <= 1'b0;
    end
  end

  // ====================================================================
  // read channel
  // ====================================================================
  always_comb
  begin
    rd_mux  = '0;
    rd_resp = axil_pkg::resp_okay;
    case (req.araddr)
      axil_pkg::reg_ctrl_addr:
      begin
        rd_mux[0] = ctrl_q.enable;
        rd_mux[1] = ctrl_q.dir;
        rd_mux[8 +: motor_cfg_pkg::pwm_res] = ctrl_q.duty;
      end
      axil_pkg::reg_pos_addr:
        rd_mux = enc.position;
      axil_pkg::reg_status_addr:
      begin
        rd_mux[1:0] = keys.key_n;                    // 1 = released
        rd_mux[8 +: motor_cfg_pkg::err_w] = enc.err_count;
      end
      default:
        rd_resp = axil_pkg::resp_slverr;             // data stays zero
    endcase
  end

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rresp_q   <= axil_pkg::resp_okay;
    end
    else
    begin
      arready_q <= req.arvalid & ~rvalid_q & ~arready_q;
      if (rd_hs)
      begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_resp;
      end
      else if (rvalid_q && req.rready)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge fpga_clk_50)
  begin
    if (rd_hs)
      rdata_q <= rd_mux;   // sampled with arready
  end

  // ====================================================================
  // outputs
  // ====================================================================
  assign rsp.awready = awready_q;
  assign rsp.wready  = awready_q;
  assign rsp.bresp   = bresp_q;
  assign rsp.bvalid  = bvalid_q;
  assign rsp.arready = arready_q;
  assign rsp.rdata   = rdata_q;
  assign rsp.rresp   = rresp_q;
  assign rsp.rvalid  = rvalid_q;
  assign ctrl        = ctrl_q;

endmodule

// ==== src/robot_io_top.sv ====
`timescale 1ns/1ps

module robot_io_top (
  input  logic                      fpga_clk_50,
  input  logic                      hps_fpga_reset_n,
  input  axil_pkg::axil_req_t       axil_req,
  output axil_pkg::axil_rsp_t       axil_rsp,
  input  motor_cfg_pkg::enc_pins_t  enc_raw,   // straight from the encoder header
  input  motor_cfg_pkg::key_pins_t  key_raw,   // board keys, active low
  output logic                      pwm_out,
  output logic                      motor_dir
);

  motor_cfg_pkg::enc_pins_t   enc_clean;
  motor_cfg_pkg::key_pins_t   key_clean;
  motor_cfg_pkg::enc_status_t enc_status;
  motor_cfg_pkg::motor_ctrl_t motor_ctrl;

  // ====================================================================
  // encoder path, filter then decode
  // ====================================================================
  debounce_filter #(
    .payload_t (motor_cfg_pkg::enc_pins_t),
    .rst_val   ('0)
  ) enc_filter (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .raw              (enc_raw),
    .clean            (enc_clean)
  );

  quad_decoder quad_decoder (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .pins             (enc_clean),
    .status           (enc_status)
  );

  // keys idle high, so the filter starts released
  debounce_filter #(
    .payload_t (motor_cfg_pkg::key_pins_t),
    .rst_val   ('1)
  ) key_filter (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .raw              (key_raw),
    .clean            (key_clean)
  );

  // ====================================================================
  // register block and motor drive
  // ====================================================================
  axil_regs axil_regs (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (axil_req),
    .rsp              (axil_rsp),
    .enc              (enc_status),
    .keys             (key_clean),
    .ctrl             (motor_ctrl)
  );

  pwm_generator pwm_generator (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ctrl             (motor_ctrl),
    .pwm_out          (pwm_out)
  );

  assign motor_dir = motor_ctrl.dir;   // follows CTRL right away

endmodule

// ==== bench/tb_robot_io.sv ====
`timescale 1ns/1ps

module tb_robot_io;

  localparam int step_cycles    = motor_cfg_pkg::debounce_cycles + 8;  // one encoder state
  localparam int pwm_period     = (2 ** motor_cfg_pkg::pwm_res) * motor_cfg_pkg::pwm_tick_div;
  localparam int hs_limit       = 20;                                  // cycles per handshake
  // 40 encoder steps, three pwm windows of ~8000, margin
  localparam int timeout_cycles = 40 * step_cycles + 3 * 8000 + 36_000;

  logic fpga_clk_50;
  logic hps_fpga_reset_n;
  axil_pkg::axil_req_t        req;
  axil_pkg::axil_rsp_t        rsp;
  motor_cfg_pkg::enc_pins_t   enc_raw;
  motor_cfg_pkg::key_pins_t   key_raw;
  logic pwm_out;
  logic motor_dir;

  int          mismatch_cnt;
  int          proto_cnt;
  int          cycle_cnt;
  logic [31:0] lcg_state = 32'd75328;
  int          enc_idx;      // position in the gray sequence
  int          n_fwd;
  int          m_rev;
  int          duty;
  int          high_cnt;
  logic        dir;
  logic        bvalid_d;
  logic        bready_d;

  robot_io_top uut (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .axil_req         (req),
    .axil_rsp         (rsp),
    .enc_raw          (enc_raw),
    .key_raw          (key_raw),
    .pwm_out          (pwm_out),
    .motor_dir        (motor_dir)
  );

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #2 fpga_clk_50 = ~fpga_clk_50;  // 4 ns period
  end

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;  // low bits are weak
  endfunction

  function automatic logic [1:0] enc_code(input int idx);
    case (idx & 3)
      0: return 2'b00;
      1: return 2'b10;  // a leads
      2: return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic bus_write(input logic [axil_pkg::axil_addr_w-1:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [1:0] exp_resp, input string what);
    int n;
    req.awaddr  <= addr;
    req.awvalid <= 1'b1;
    req.wdata   <= data;
    req.wstrb   <= strb;
    req.wvalid  <= 1'b1;
    n = 0;
    do
    begin
      @(posedge fpga_clk_50);
      n++;
    end while (!(rsp.awready && rsp.wready) && n < hs_limit);
    if (!(rsp.awready && rsp.wready))
    begin
      $display("write to %h got no awready/wready", addr);
      proto_cnt++;
    end
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    n = 0;
    do
    begin
      @(posedge fpga_clk_50);
      n++;
    end while (!rsp.bvalid && n < hs_limit);
    if (!rsp.bvalid)
    begin
      $display("write to %h got no write response", addr);
      proto_cnt++;
    end
    check_eq(what, rsp.bresp, exp_resp);
    repeat (2) @(posedge fpga_clk_50);  // stall bready while bvalid holds
    req.bready <= 1'b1;
    @(posedge fpga_clk_50);
    req.bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [axil_pkg::axil_addr_w-1:0] addr,
                          input logic [31:0] exp_data, input logic [1:0] exp_resp,
                          input string what);
    int n;
    req.araddr  <= addr;
    req.arvalid <= 1'b1;
    n = 0;
    do
    begin
      @(posedge fpga_clk_50);
      n++;
    end while (!rsp.arready && n < hs_limit);
    if (!rsp.arready)
    begin
      $display("read of %h got no arready", addr);
      proto_cnt++;
    end
    req.arvalid <= 1'b0;
    n = 0;
    do
    begin
      @(posedge fpga_clk_50);
      n++;
    end while (!rsp.rvalid && n < hs_limit);
    if (!rsp.rvalid)
    begin
      $display("read of %h got no read data", addr);
      proto_cnt++;
    end
    check_eq(what, rsp.rdata, exp_data);
    check_eq({what, " resp"}, rsp.rresp, exp_resp);
    req.rready <= 1'b1;
    @(posedge fpga_clk_50);
    req.rready <= 1'b0;
  endtask

  task automatic enc_step(input int delta);
    enc_idx = (enc_idx + delta) & 3;
    enc_raw <= enc_code(enc_idx);
    repeat (step_cycles) @(posedge fpga_clk_50);  // past the filter and decoder
  endtask

  // ====================================================================
  // bus protocol watch and run limit
  // ====================================================================
  always @(posedge fpga_clk_50)
  begin
    if (hps_fpga_reset_n && bvalid_d && !bready_d)
    begin
      assert (rsp.bvalid)
      else
      begin
        $display("bvalid dropped at %0t before bready was seen", $time);
        proto_cnt++;
      end
    end
    bvalid_d <= rsp.bvalid;
    bready_d <= req.bready;
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ====================================================================
  // test sequence
  // ====================================================================
  initial
  begin
    hps_fpga_reset_n = 1'b0;
    req              = '0;
    enc_raw          = '0;
    key_raw          = '1;  // keys released
    bvalid_d         = 1'b0;
    bready_d         = 1'b0;
    enc_idx          = 0;
    repeat (16) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;

    // quiet outputs after reset
    repeat (8)
    begin
      @(posedge fpga_clk_50);
      check_eq("idle outputs", {pwm_out, motor_dir, rsp.awready, rsp.wready, rsp.bvalid,
                                rsp.arready, rsp.rvalid}, 7'b0000000);
    end
    bus_read(axil_pkg::reg_ctrl_addr, 32'h0, axil_pkg::resp_okay, "reset ctrl");
    bus_read(axil_pkg::reg_pos_addr, 32'h0, axil_pkg::resp_okay, "reset position");
    bus_read(axil_pkg::reg_status_addr, 32'h3, axil_pkg::resp_okay, "reset status");

    // only enable, dir and duty bits stick in CTRL
    bus_write(axil_pkg::reg_ctrl_addr, 32'h1234_a503, 4'hf, axil_pkg::resp_okay, "ctrl wr");
    bus_read(axil_pkg::reg_ctrl_addr, 32'h0000_a503, axil_pkg::resp_okay, "ctrl rd");
    bus_write(axil_pkg::reg_ctrl_addr, 32'h0000_5a00, 4'h2, axil_pkg::resp_okay, "strb wr");
    bus_read(axil_pkg::reg_ctrl_addr, 32'h0000_5a03, axil_pkg::resp_okay, "strb rd");
    bus_write(axil_pkg::reg_pos_addr, 32'hdead_beef, 4'hf, axil_pkg::resp_okay, "pos wr");
    bus_read(axil_pkg::reg_pos_addr, 32'h0, axil_pkg::resp_okay, "pos after wr");
    bus_write(4'hc, 32'h1, 4'hf, axil_pkg::resp_slverr, "unmapped wr");
    bus_read(4'hc, 32'h0, axil_pkg::resp_slverr, "unmapped rd");

    // pwm with a nonzero duty from the lcg
    duty = 1 + next_rand() % 255;
    dir  = next_rand() & 1;
    bus_write(axil_pkg::reg_ctrl_addr, (duty << 8) | (dir << 1) | 1, 4'hf,
              axil_pkg::resp_okay, "pwm ctrl wr");
    check_eq("motor_dir", motor_dir, dir);
    repeat (pwm_period + 8) @(posedge fpga_clk_50);  // let the new period start
    high_cnt = 0;
    repeat (pwm_period)
    begin
      @(posedge fpga_clk_50);
      if (pwm_out)
        high_cnt++;
    end
    check_eq("pwm high cycles", high_cnt, duty * motor_cfg_pkg::pwm_tick_div);
    bus_write(axil_pkg::reg_ctrl_addr, (duty << 8) | (dir << 1), 4'hf,
              axil_pkg::resp_okay, "pwm off wr");
    repeat (pwm_period + 8) @(posedge fpga_clk_50);
    high_cnt = 0;
    repeat (pwm_period)
    begin
      @(posedge fpga_clk_50);
      if (pwm_out)
        high_cnt++;
    end
    check_eq("pwm disabled high cycles", high_cnt, 0);

    // encoder steps forward then back
    n_fwd = 5 + next_rand() % 16;
    m_rev = 1 + next_rand() % 15;
    repeat (n_fwd) enc_step(1);
    repeat (m_rev) enc_step(-1);
    bus_read(axil_pkg::reg_pos_addr, n_fwd - m_rev, axil_pkg::resp_okay, "position");
    enc_raw.a <= ~enc_raw.a;  // short glitch on a
    repeat (96) @(posedge fpga_clk_50);
    bus_read(axil_pkg::reg_pos_addr, n_fwd - m_rev, axil_pkg::resp_okay, "pos during glitch");
    enc_raw.a <= ~enc_raw.a;  // read above brings the pulse to 100 cycles
    repeat (step_cycles) @(posedge fpga_clk_50);
    bus_read(axil_pkg::reg_pos_addr, n_fwd - m_rev, axil_pkg::resp_okay, "pos after glitch");

    // both channels at once is a decode error
    enc_step(2);
    bus_read(axil_pkg::reg_pos_addr, n_fwd - m_rev, axil_pkg::resp_okay, "pos after error");
    bus_read(axil_pkg::reg_status_addr, 32'h0000_0103, axil_pkg::resp_okay, "err status");

    // long key press is seen and a short tap is filtered
    key_raw.key_n[0] <= 1'b0;
    repeat (step_cycles) @(posedge fpga_clk_50);
    bus_read(axil_pkg::reg_status_addr, 32'h0000_0102, axil_pkg::resp_okay, "key held");
    key_raw.key_n[0] <= 1'b1;
    repeat (step_cycles) @(posedge fpga_clk_50);
    key_raw.key_n[0] <= 1'b0;
    repeat (96) @(posedge fpga_clk_50);
    bus_read(axil_pkg::reg_status_addr, 32'h0000_0103, axil_pkg::resp_okay, "key tap");
    key_raw.key_n[0] <= 1'b1;
    repeat (step_cycles) @(posedge fpga_clk_50);
    bus_read(axil_pkg::reg_status_addr, 32'h0000_0103, axil_pkg::resp_okay, "key after tap");

    $display("errors: %0d mismatches, %0d protocol", mismatch_cnt, proto_cnt);
    if (mismatch_cnt == 0 && proto_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
src/motor_cfg_pkg.sv
src/axil_pkg.sv
src/debounce_filter.sv
src/quad_decoder.sv
src/pwm_generator.sv
src/axil_regs.sv
src/robot_io_top.sv
bench/tb_robot_io.sv
